//--- design/psr_config.svh
`ifndef PSR_CONFIG_SVH
`define PSR_CONFIG_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------
`define PSR_DATA_W     32        // register write data and operands
`define PSR_IPSR_W     6         // exception number field

// ----------------------------------------
// reset values
// ----------------------------------------
`define PSR_IPSR_RST   6'd3      // come out of reset at HardFault priority
`define PSR_FLAGS_RST  4'b1100   // N,Z set / C,V clear, arbitrary but known

// architected exception numbers
`define PSR_NMI_NUM    6'd2
`define PSR_HDF_NUM    6'd3

// ----------------------------------------
// options
// ----------------------------------------
// multiplier result joins the result merge while this is nonzero,
// 0 drops the whole multiplier path from the merge
`define PSR_HAS_MUL    1

`endif

//--- design/psr_pkg.sv
`include "psr_config.svh"

package psr_pkg;

   // ----------------------------------------
   // architectural flags, same order as xPSR[31:28]
   // ----------------------------------------
   typedef struct packed {
      logic n;                                   // negative
      logic z;                                   // zero
      logic c;                                   // carry / not borrow
      logic v;                                   // overflow
   } flags_t;

   // Bcc condition field, bit 0 inverts the sense
   typedef enum logic [3:0] {
      EQ = 4'b0000, NE = 4'b0001, CS = 4'b0010, CC = 4'b0011,
      MI = 4'b0100, PL = 4'b0101, VS = 4'b0110, VC = 4'b0111,
      HI = 4'b1000, LS = 4'b1001, GE = 4'b1010, LT = 4'b1011,
      GT = 4'b1100, LE = 4'b1101, AL = 4'b1110, NV = 4'b1111
   } cc_code_e;

   // MSR target, codes 01 and 11 write nothing here
   typedef enum logic [1:0] {
      SYS_APSR    = 2'b00,
      SYS_PRIMASK = 2'b10
   } sysreg_e;

   // where an xPSR load takes its value from
   typedef enum logic {
      XPSR_RETURN = 1'b0,                        // popped frame, via shifter result
      XPSR_ENTRY  = 1'b1                         // new exception number
   } xpsr_src_e;

   // ----------------------------------------
   // execute stage results
   // ----------------------------------------
   typedef struct packed {
      logic [`PSR_DATA_W-1:0] alu_res;
      logic [`PSR_DATA_W-1:0] mul_res;
      logic [`PSR_DATA_W-1:0] spu_res;           // shift / permute unit
      logic                   alu_c;
      logic                   alu_v;
      logic                   spu_n;
      logic                   spu_z;
      logic                   spu_c;
      logic                   spu_sel;           // flags come from the shifter
   } exec_result_t;

   // decode controls, one-cycle strobes
   typedef struct packed {
      logic      nz_en;
      logic      c_en;
      logic      v_en;
      logic      msr_en;
      sysreg_e   msr_sel;
      logic      xpsr_en;
      xpsr_src_e xpsr_src;
      logic      cps_en;
      logic      cps_disable;                    // 1 = CPSID, 0 = CPSIE
   } psr_ctl_t;

   // merged result plus candidate flags from execute
   typedef struct packed {
      logic [`PSR_DATA_W-1:0] res;
      flags_t                 flags;
   } cand_t;

endpackage

//--- design/psr_result_merge.sv
`timescale 1ns/1ps
`include "psr_config.svh"

module psr_result_merge (
   input  psr_pkg::exec_result_t exec_i,         // results from execute units
   output psr_pkg::cand_t        cand_o          // merged result, candidate flags
);

   // ----------------------------------------
   // result merge
   // ----------------------------------------
   // only one unit drives a nonzero result in any cycle,
   // the others return zero, so a plain OR selects it

   logic [`PSR_DATA_W-1:0] mul_res;              // multiplier, or zero when absent
   logic [`PSR_DATA_W-1:0] add_mul;              // ALU and multiplier combined
   logic                   add_mul_z;            // zero detect of add_mul

   assign mul_res   = (`PSR_HAS_MUL != 0) ? exec_i.mul_res : '0;
   assign add_mul   = exec_i.alu_res | mul_res;
   assign add_mul_z = ~|add_mul;

   assign cand_o.res = exec_i.spu_res | add_mul;

   // ----------------------------------------
   // candidate flags
   // ----------------------------------------
   // shift instructions report their own N,Z,C;
   // everything else derives N,Z from the ALU/MUL value

   always_comb begin
      if (exec_i.spu_sel) begin
         cand_o.flags.n = exec_i.spu_n;
         cand_o.flags.z = exec_i.spu_z;
         cand_o.flags.c = exec_i.spu_c;           // shifter carry out
      end else begin
         cand_o.flags.n = add_mul[`PSR_DATA_W-1]; // sign bit
         cand_o.flags.z = add_mul_z;
         cand_o.flags.c = exec_i.alu_c;
      end
      // overflow only ever comes from the adder
      cand_o.flags.v = exec_i.alu_v;
   end

endmodule

//--- design/psr_flag_regs.sv
`timescale 1ns/1ps
`include "psr_config.svh"

module psr_flag_regs (
   input  logic               hclk,
   input  logic               hreset_n,
   input  logic               hready_i,      // core advance
   input  psr_pkg::psr_ctl_t  ctl_i,         // decode strobes
   input  psr_pkg::cand_t     cand_i,        // candidate flags from merge
   input  logic               alu_v_i,       // adder overflow
   input  logic [3:0]         msr_nzcv_i,    // MSR operand bits 31:28
   input  logic [3:0]         spu_nzcv_i,    // popped xPSR bits 31:28
   output psr_pkg::flags_t    flags_o,       // architectural NZCV
   output psr_pkg::flags_t    flags_fwd_o    // NZCV forwarded from execute
);

   psr_pkg::flags_t flags_q;                 // NZCV registers
   psr_pkg::flags_t flags_nxt;               // selected next value
   psr_pkg::flags_t exec_flags;              // execute candidates

   logic ldr_flags;                          // exception return restores NZCV
   logic msr_flags;                          // MSR APSR writes NZCV
   logic std_flags;                          // ordinary data processing update
   logic nz_ena;
   logic c_ena;
   logic v_ena;

   // ----------------------------------------
   // source selection
   // ----------------------------------------
   assign ldr_flags = ctl_i.xpsr_en & (ctl_i.xpsr_src == psr_pkg::XPSR_RETURN);
   assign msr_flags = ctl_i.msr_en & (ctl_i.msr_sel == psr_pkg::SYS_APSR);
   assign std_flags = ~(ldr_flags | msr_flags);

   // V taken straight from the adder
   assign exec_flags = {cand_i.flags.n, cand_i.flags.z, cand_i.flags.c, alu_v_i};

   always_comb begin
      if (ldr_flags) begin
         flags_nxt = spu_nzcv_i;             // restore from stacked frame
      end else if (msr_flags) begin
         flags_nxt = msr_nzcv_i;
      end else begin
         flags_nxt = exec_flags;
      end
   end

   // a load or MSR writes all four, else each flag by its own enable
   assign nz_ena = hready_i & (ctl_i.nz_en | ~std_flags);
   assign c_ena  = hready_i & (ctl_i.c_en  | ~std_flags);
   assign v_ena  = hready_i & (ctl_i.v_en  | ~std_flags);

   // ----------------------------------------
   // NZCV registers
   // ----------------------------------------
   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         flags_q <= `PSR_FLAGS_RST;
      end else begin
         if (nz_ena) begin
            flags_q.n <= flags_nxt.n;
            flags_q.z <= flags_nxt.z;        // N and Z always move together
         end
         if (c_ena) begin
            flags_q.c <= flags_nxt.c;
         end
         if (v_ena) begin
            flags_q.v <= flags_nxt.v;
         end
      end
   end

   assign flags_o = flags_q;

   // ----------------------------------------
   // forwarding to condition evaluation
   // ----------------------------------------
   // a Bcc behind an MSR gets refetched, so only the execute
   // enables matter here and the MSR/load paths stay off the late path
   assign flags_fwd_o.n = ctl_i.nz_en ? exec_flags.n : flags_q.n;
   assign flags_fwd_o.z = ctl_i.nz_en ? exec_flags.z : flags_q.z;
   assign flags_fwd_o.c = ctl_i.c_en  ? exec_flags.c : flags_q.c;
   assign flags_fwd_o.v = ctl_i.v_en  ? exec_flags.v : flags_q.v;

endmodule

//--- design/psr_cond_eval.sv
`timescale 1ns/1ps

module psr_cond_eval (
   input  psr_pkg::cc_code_e cc_code_i,      // Bcc condition field
   input  psr_pkg::flags_t   flags_i,        // forwarded NZCV
   output logic              cc_pass_o       // branch is taken
);

   // ----------------------------------------
   // code reduction
   // ----------------------------------------
   // every even code reduces to
   //   ((N|mn) == (V|mv)) & (mz | (Z^iz)) & (C|mc)
   // a set mask bit takes that flag out of the test;
   // the odd code of each pair is the inverse

   logic mask_n;
   logic mask_z;
   logic mask_c;
   logic mask_v;
   logic inv_z;                              // test Z clear instead of set
   logic pass_z;
   logic pass_even;                          // result before the bit 0 inversion

   always_comb begin
      // all masked, so AL/NV land on 1 and 0
      {mask_n, mask_z, mask_c, mask_v, inv_z} = 5'b11110;
      case (cc_code_i)
         psr_pkg::EQ, psr_pkg::NE: mask_z = 1'b0;              // Z
         psr_pkg::CS, psr_pkg::CC: mask_c = 1'b0;              // C
         psr_pkg::MI, psr_pkg::PL: mask_n = 1'b0;              // N == 1
         psr_pkg::VS, psr_pkg::VC: mask_v = 1'b0;              // 1 == V
         psr_pkg::HI, psr_pkg::LS: begin
            mask_c = 1'b0;                   // C set
            mask_z = 1'b0;
            inv_z  = 1'b1;                   // and Z clear
         end
         psr_pkg::GE, psr_pkg::LT: begin
            mask_n = 1'b0;                   // N == V
            mask_v = 1'b0;
         end
         psr_pkg::GT, psr_pkg::LE: begin
            mask_n = 1'b0;
            mask_v = 1'b0;
            mask_z = 1'b0;
            inv_z  = 1'b1;                   // N == V and Z clear
         end
         default: ;                          // reserved codes
      endcase
   end

   // ----------------------------------------
   // evaluation
   // ----------------------------------------
   assign pass_z    = mask_z | (flags_i.z ^ inv_z);
   assign pass_even = ((flags_i.n | mask_n) == (flags_i.v | mask_v)) &
                      pass_z & (flags_i.c | mask_c);

   assign cc_pass_o = pass_even ^ cc_code_i[0];

endmodule

//--- design/psr_mask_ipsr.sv
`timescale 1ns/1ps
`include "psr_config.svh"

module psr_mask_ipsr (
   input  logic                   hclk,
   input  logic                   hreset_n,
   input  logic                   hready_i,         // core advance
   input  psr_pkg::psr_ctl_t      ctl_i,            // decode strobes
   input  logic                   msr_bit0_i,       // MSR operand bit 0
   input  logic [`PSR_IPSR_W-1:0] spu_ipsr_i,       // popped xPSR exception number
   input  logic [`PSR_IPSR_W-1:0] int_num_i,        // exception being entered
   input  logic                   svc_escalate_i,   // SVCall priority too low
   output logic [`PSR_IPSR_W-1:0] ipsr_o,
   output logic                   primask_o,
   output logic                   primask_ex_o,     // next PRIMASK, forwarded
   output logic                   handler_o,        // handler mode
   output logic                   nmi_active_o,
   output logic                   hdf_active_o,
   output logic                   svc_is_undef_o
);

   logic                   primask_q;
   logic                   msr_primask;             // MSR targeting PRIMASK
   logic                   primask_en;
   logic                   primask_nxt;
   logic [`PSR_IPSR_W-1:0] ipsr_q;
   logic [`PSR_IPSR_W-1:0] ipsr_nxt;

   // ----------------------------------------
   // PRIMASK
   // ----------------------------------------
   // raised by MSR or CPSID, blocks all but NMI and HardFault
   assign msr_primask = ctl_i.msr_en & (ctl_i.msr_sel == psr_pkg::SYS_PRIMASK);
   assign primask_en  = msr_primask | ctl_i.cps_en;
   assign primask_nxt = (msr_primask & msr_bit0_i) |
                        (ctl_i.cps_en & ctl_i.cps_disable);

   // CPSID has to take effect exactly at the instruction boundary,
   // so execute sees the value before it is registered
   assign primask_ex_o = primask_en ? primask_nxt : primask_q;

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         primask_q <= 1'b0;
      end else if (hready_i & primask_en) begin
         primask_q <= primask_nxt;
      end
   end

   // ----------------------------------------
   // exception number
   // ----------------------------------------
   // not writable by software, only by entry and return
   assign ipsr_nxt = (ctl_i.xpsr_src == psr_pkg::XPSR_RETURN) ? spu_ipsr_i
                                                               : int_num_i;

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         ipsr_q <= `PSR_IPSR_RST;            // faults during boot lock up at HardFault
      end else if (hready_i & ctl_i.xpsr_en) begin
         ipsr_q <= ipsr_nxt;
      end
   end

   // ----------------------------------------
   // mode decode
   // ----------------------------------------
   assign handler_o    = |ipsr_q;            // 0 is thread mode
   assign nmi_active_o = (ipsr_q == `PSR_NMI_NUM);
   assign hdf_active_o = (ipsr_q == `PSR_HDF_NUM);

   // SVC cannot be taken at or above its own priority
   assign svc_is_undef_o = nmi_active_o | hdf_active_o | primask_q | svc_escalate_i;

   assign ipsr_o    = ipsr_q;
   assign primask_o = primask_q;

endmodule

//--- design/psr_top.sv
`timescale 1ns/1ps
`include "psr_config.svh"

module psr_top (
   input  logic                   hclk,
   input  logic                   hreset_n,
   input  logic                   hready_i,
   input  psr_pkg::exec_result_t  exec_i,         // execute results
   input  psr_pkg::psr_ctl_t      ctl_i,          // decode strobes
   input  logic [`PSR_DATA_W-1:0] msr_data_i,     // MSR source register
   input  logic [`PSR_IPSR_W-1:0] int_num_i,      // exception on entry
   input  psr_pkg::cc_code_e      cc_code_i,      // Bcc condition
   input  logic                   svc_escalate_i,
   output logic [`PSR_DATA_W-1:0] wdata_o,        // register file write data
   output psr_pkg::flags_t        apsr_o,
   output logic [`PSR_IPSR_W-1:0] ipsr_o,
   output logic                   primask_o,
   output logic                   primask_ex_o,
   output logic                   cc_pass_o,
   output logic                   handler_o,
   output logic                   nmi_active_o,
   output logic                   hdf_active_o,
   output logic                   svc_is_undef_o
);

   psr_pkg::cand_t  cand;                        // merged result and candidates
   psr_pkg::flags_t flags_fwd;                   // flags seen by Bcc

   // ----------------------------------------
   // front stage
   // ----------------------------------------
   psr_result_merge i_merge (
      .exec_i (exec_i),
      .cand_o (cand)
   );

   assign wdata_o = cand.res;

   // ----------------------------------------
   // register stage
   // ----------------------------------------
   psr_flag_regs i_flags (
      .hclk        (hclk),
      .hreset_n    (hreset_n),
      .hready_i    (hready_i),
      .ctl_i       (ctl_i),
      .cand_i      (cand),
      .alu_v_i     (exec_i.alu_v),
      .msr_nzcv_i  (msr_data_i[`PSR_DATA_W-1 -: 4]),      // APSR field
      .spu_nzcv_i  (exec_i.spu_res[`PSR_DATA_W-1 -: 4]),  // stacked APSR
      .flags_o     (apsr_o),
      .flags_fwd_o (flags_fwd)
   );

   psr_cond_eval i_cond (
      .cc_code_i (cc_code_i),
      .flags_i   (flags_fwd),
      .cc_pass_o (cc_pass_o)
   );

   psr_mask_ipsr i_mask (
      .hclk           (hclk),
      .hreset_n       (hreset_n),
      .hready_i       (hready_i),
      .ctl_i          (ctl_i),
      .msr_bit0_i     (msr_data_i[0]),
      .spu_ipsr_i     (exec_i.spu_res[`PSR_IPSR_W-1:0]), // stacked IPSR field
      .int_num_i      (int_num_i),
      .svc_escalate_i (svc_escalate_i),
      .ipsr_o         (ipsr_o),
      .primask_o      (primask_o),
      .primask_ex_o   (primask_ex_o),
      .handler_o      (handler_o),
      .nmi_active_o   (nmi_active_o),
      .hdf_active_o   (hdf_active_o),
      .svc_is_undef_o (svc_is_undef_o)
   );

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter real PERIOD_NS  = 40.0,     // hclk period
   parameter int  RST_CYCLES = 5         // cycles held in reset
) (
   output logic hclk_o,
   output logic hreset_n_o
);

   initial begin
      hclk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) hclk_o = ~hclk_o;
   end

   // release on a falling edge, away from the register clock edge
   initial begin
      hreset_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge hclk_o);
      @(negedge hclk_o);
      hreset_n_o = 1'b1;
   end

endmodule

//--- dv/tb_psr.sv
`timescale 1ns/1ps
`include "psr_config.svh"

module tb_psr;

   // ----------------------------------------
   // DUT signals
   // ----------------------------------------
   logic                   hclk;
   logic                   hreset_n;
   logic                   hready;
   psr_pkg::exec_result_t  exec;
   psr_pkg::psr_ctl_t      ctl;
   logic [`PSR_DATA_W-1:0] msr_data;
   logic [`PSR_IPSR_W-1:0] int_num;
   psr_pkg::cc_code_e      cc_code;
   logic                   svc_esc;
   logic [`PSR_DATA_W-1:0] wdata;
   psr_pkg::flags_t        apsr;
   logic [`PSR_IPSR_W-1:0] ipsr;
   logic                   primask;
   logic                   primask_ex;
   logic                   cc_pass;
   logic                   handler;
   logic                   nmi_active;
   logic                   hdf_active;
   logic                   svc_is_undef;

   localparam int MAX_CYCLES = 2000;   // about 870 cycles of tests, plenty of margin

   integer          seed = 52814;
   int              errors = 0;
   int              checks = 0;
   int              cycles = 0;
   string           test_name = "reset";
   psr_pkg::flags_t m_flags;                     // model of the registered state
   logic [5:0]      m_ipsr;
   logic            m_primask;

   tb_clkgen i_clkgen (.hclk_o(hclk), .hreset_n_o(hreset_n));

   psr_top i_dut (
      .hclk (hclk), .hreset_n (hreset_n), .hready_i (hready),
      .exec_i (exec), .ctl_i (ctl), .msr_data_i (msr_data),
      .int_num_i (int_num), .cc_code_i (cc_code), .svc_escalate_i (svc_esc),
      .wdata_o (wdata), .apsr_o (apsr), .ipsr_o (ipsr), .primask_o (primask),
      .primask_ex_o (primask_ex), .cc_pass_o (cc_pass), .handler_o (handler),
      .nmi_active_o (nmi_active), .hdf_active_o (hdf_active),
      .svc_is_undef_o (svc_is_undef)
   );

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   function automatic psr_pkg::cand_t merge_ref(psr_pkg::exec_result_t e);
      psr_pkg::cand_t m;
      logic [31:0]    am;                        // alu and mul combined
      am    = e.alu_res | ((`PSR_HAS_MUL != 0) ? e.mul_res : 32'h0);
      m.res = am | e.spu_res;
      if (e.spu_sel) begin
         m.flags.n = e.spu_n;
         m.flags.z = e.spu_z;
         m.flags.c = e.spu_c;
      end else begin
         m.flags.n = am[31];
         m.flags.z = (am == 32'h0);
         m.flags.c = e.alu_c;
      end
      m.flags.v = e.alu_v;
      return m;
   endfunction

   function automatic psr_pkg::flags_t flags_ref(psr_pkg::flags_t cur, psr_pkg::psr_ctl_t c,
                                                 psr_pkg::exec_result_t e, logic [31:0] msr);
      psr_pkg::flags_t f;
      psr_pkg::cand_t  m;
      f = cur;
      m = merge_ref(e);
      if (c.xpsr_en && c.xpsr_src == psr_pkg::XPSR_RETURN) begin
         f = e.spu_res[31:28];
      end else if (c.msr_en && c.msr_sel == psr_pkg::SYS_APSR) begin
         f = msr[31:28];
      end else begin
         if (c.nz_en) begin
            f.n = m.flags.n;
            f.z = m.flags.z;
         end
         if (c.c_en) f.c = m.flags.c;
         if (c.v_en) f.v = m.flags.v;
      end
      return f;
   endfunction

   // flags seen by Bcc, execute enables only
   function automatic psr_pkg::flags_t fwd_ref(psr_pkg::flags_t cur, psr_pkg::psr_ctl_t c,
                                               psr_pkg::exec_result_t e);
      psr_pkg::flags_t f;
      psr_pkg::cand_t  m;
      m   = merge_ref(e);
      f   = cur;
      f.n = c.nz_en ? m.flags.n : cur.n;
      f.z = c.nz_en ? m.flags.z : cur.z;
      f.c = c.c_en ? m.flags.c : cur.c;
      f.v = c.v_en ? m.flags.v : cur.v;
      return f;
   endfunction

   function automatic logic cc_ref(psr_pkg::cc_code_e cc, psr_pkg::flags_t f);
      case (cc)
         psr_pkg::EQ: return f.z;
         psr_pkg::NE: return !f.z;
         psr_pkg::CS: return f.c;
         psr_pkg::CC: return !f.c;
         psr_pkg::MI: return f.n;
         psr_pkg::PL: return !f.n;
         psr_pkg::VS: return f.v;
         psr_pkg::VC: return !f.v;
         psr_pkg::HI: return f.c && !f.z;
         psr_pkg::LS: return !f.c || f.z;
         psr_pkg::GE: return f.n == f.v;
         psr_pkg::LT: return f.n != f.v;
         psr_pkg::GT: return !f.z && (f.n == f.v);
         psr_pkg::LE: return f.z || (f.n != f.v);
         default:     return 1'b0;               // reserved, never driven
      endcase
   endfunction

   function automatic logic primask_ref(logic cur, psr_pkg::psr_ctl_t c, logic [31:0] msr);
      if (c.msr_en && c.msr_sel == psr_pkg::SYS_PRIMASK) return msr[0];
      if (c.cps_en) return c.cps_disable;
      return cur;
   endfunction

   function automatic logic [5:0] ipsr_ref(logic [5:0] cur, psr_pkg::psr_ctl_t c,
                                           psr_pkg::exec_result_t e, logic [5:0] num);
      if (!c.xpsr_en) return cur;
      return (c.xpsr_src == psr_pkg::XPSR_ENTRY) ? num : e.spu_res[5:0];
   endfunction

   // ----------------------------------------
   // checking
   // ----------------------------------------
   task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s expected %h actual %h at %0t",
                  test_name, sig, exp, act, $time);
      end
   endtask

   // same-cycle outputs compared at the edge before the registers move
   // then the model steps and registered outputs are compared just after
   always @(posedge hclk) begin
      if (hreset_n) begin
         check_value("wdata", merge_ref(exec).res, wdata);
         check_value("primask_ex", primask_ref(m_primask, ctl, msr_data), primask_ex);
         check_value("cc_pass", cc_ref(cc_code, fwd_ref(m_flags, ctl, exec)), cc_pass);
      end
      if (!hreset_n) begin
         m_flags   = `PSR_FLAGS_RST;
         m_ipsr    = `PSR_IPSR_RST;
         m_primask = 1'b0;
      end else if (hready) begin
         m_flags   = flags_ref(m_flags, ctl, exec, msr_data);
         m_primask = primask_ref(m_primask, ctl, msr_data);
         m_ipsr    = ipsr_ref(m_ipsr, ctl, exec, int_num);
      end
      #1;
      if (hreset_n) begin
         check_value("apsr", m_flags, apsr);
         check_value("ipsr", m_ipsr, ipsr);
         check_value("primask", m_primask, primask);
         check_value("handler", m_ipsr != 0, handler);
         check_value("nmi_active", m_ipsr == `PSR_NMI_NUM, nmi_active);
         check_value("hdf_active", m_ipsr == `PSR_HDF_NUM, hdf_active);
         check_value("svc_is_undef", (m_ipsr == `PSR_NMI_NUM) | (m_ipsr == `PSR_HDF_NUM) |
                     m_primask | svc_esc, svc_is_undef);
      end
   end

   always @(posedge hclk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
         $display("errors %0d checks %0d", errors, checks);
         $display("TEST FAIL");
         $finish;
      end
   end

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   task automatic idle();
      @(negedge hclk);
      exec     = '0;
      ctl      = '0;
      msr_data = '0;
      int_num  = '0;
      svc_esc  = 1'b0;
      hready   = 1'b1;
   endtask

   // one execute unit nonzero, the others return zero
   task automatic rand_exec();
      int unsigned src;
      src  = $unsigned($random(seed)) % 3;
      exec = '0;
      case (src)
         0: exec.alu_res = $random(seed);
         1: exec.mul_res = $random(seed);
         default: exec.spu_res = $random(seed);
      endcase
      if ($unsigned($random(seed)) % 8 == 0) exec.alu_res = '0;   // hit the zero flag
      {exec.alu_c, exec.alu_v, exec.spu_n, exec.spu_z, exec.spu_c, exec.spu_sel} = $random(seed);
   endtask

   initial begin
      hready   = 1'b1;
      exec     = '0;
      ctl      = '0;
      msr_data = '0;
      int_num  = '0;
      cc_code  = psr_pkg::EQ;
      svc_esc  = 1'b0;
      @(posedge hreset_n);
      idle();

      test_name = "merge";
      repeat (80) begin
         @(negedge hclk);
         rand_exec();
         {ctl.nz_en, ctl.c_en, ctl.v_en} = $random(seed);
         hready = ($unsigned($random(seed)) % 4) != 0;               // low one time in four
      end
      idle();

      test_name = "msr_xpsr";
      repeat (20) begin
         @(negedge hclk);
         exec           = '0;
         ctl            = '0;
         msr_data       = $random(seed);
         ctl.msr_en     = 1'b1;
         ctl.msr_sel    = psr_pkg::SYS_APSR;
         @(negedge hclk);
         ctl            = '0;
         exec.spu_res   = {$random(seed)} & 32'hF000_0000 | {26'h0, m_ipsr}; // keep IPSR
         ctl.xpsr_en    = 1'b1;
         ctl.xpsr_src   = psr_pkg::XPSR_RETURN;
      end
      idle();

      test_name = "cond";
      for (int cc = 0; cc < 14; cc++) begin
         repeat (16) begin
            @(negedge hclk);
            cc_code     = psr_pkg::cc_code_e'(cc);
            exec        = '0;
            ctl         = '0;
            msr_data    = $random(seed);
            ctl.msr_en  = 1'b1;
            ctl.msr_sel = psr_pkg::SYS_APSR;
            @(negedge hclk);
            ctl         = '0;                    // registered flags
            @(negedge hclk);
            rand_exec();                         // forwarded flags
            {ctl.nz_en, ctl.c_en, ctl.v_en} = 3'b111;
         end
      end
      idle();

      test_name = "primask";
      repeat (40) begin
         @(negedge hclk);
         ctl      = '0;
         msr_data = $random(seed);
         svc_esc  = $random(seed);
         if ($random(seed) & 1) begin
            ctl.msr_en  = 1'b1;
            ctl.msr_sel = psr_pkg::SYS_PRIMASK;
         end else begin
            ctl.cps_en      = 1'b1;
            ctl.cps_disable = $random(seed);
         end
      end
      idle();

      test_name = "ipsr";
      for (int i = 0; i < 8; i++) begin
         @(negedge hclk);
         ctl          = '0;
         ctl.xpsr_en  = 1'b1;
         ctl.xpsr_src = psr_pkg::XPSR_ENTRY;
         int_num      = (i == 0) ? 6'd2 : (i == 1) ? 6'd3 : 6'($random(seed));
         svc_esc      = 1'b0;
         @(negedge hclk);
         ctl          = '0;
      end
      @(negedge hclk);
      ctl          = '0;
      exec         = '0;                         // return to thread mode
      ctl.xpsr_en  = 1'b1;
      ctl.xpsr_src = psr_pkg::XPSR_RETURN;
      idle();
      idle();
      idle();

      $display("errors %0d checks %0d", errors, checks);
      if (errors == 0 && checks > 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+design
design/psr_pkg.sv
design/psr_result_merge.sv
design/psr_flag_regs.sv
design/psr_cond_eval.sv
design/psr_mask_ipsr.sv
design/psr_top.sv
dv/tb_clkgen.sv
dv/tb_psr.sv

//--- Bender.yml
package:
  name: psr

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/psr_pkg.sv
      - design/psr_result_merge.sv
      - design/psr_flag_regs.sv
      - design/psr_cond_eval.sv
      - design/psr_mask_ipsr.sv
      - design/psr_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_clkgen.sv
      - dv/tb_psr.sv
